// File: hw/core_pkg.sv
package core_pkg;

    localparam int xlen      = 64;
    localparam int reg_count = 32;
    localparam int shamt_w   = 6;   // Enough to shift across xlen

    typedef logic [xlen-1:0]              word_t;
    typedef logic [31:0]                  inst_t;
    typedef logic [$clog2(reg_count)-1:0] reg_idx_t;

    // Major opcodes kept by the core, everything else decodes as a no-op
    typedef enum logic [6:0] {
        op_reg = 7'b0110011,
        op_imm = 7'b0010011,
        op_lui = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_sll    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_slt    = 4'd8,
        alu_sltu   = 4'd9,
        alu_pass_b = 4'd10  // lui
    } alu_op_e;

endpackage

// File: hw/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  core_pkg::inst_t    inst,
    output core_pkg::alu_op_e  alu_op,
    output logic               use_imm,
    output core_pkg::word_t    imm,
    output core_pkg::reg_idx_t rd,
    output logic               writes_rd,
    output logic               rs1_used,
    output logic               rs2_used
);
    import core_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;        // funct7 bit 5
    logic       kept;
    word_t      imm_i;
    word_t      imm_u;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign alt    = inst[30];
    assign rd     = inst[11:7];

    assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
    assign imm_u = {{(xlen-32){inst[31]}}, inst[31:12], 12'b0};

    // Shared funct3 table, sub only exists in the register form
    function automatic alu_op_e funct_op(input logic [2:0] f3, input logic f7b5,
                                         input logic is_reg);
        alu_op_e op;
        case (f3)
            3'b000: begin
                if (f7b5 && is_reg)
                    op = alu_sub;
                else
                    op = alu_add;
            end
            3'b001: op = alu_sll;
            3'b010: op = alu_slt;
            3'b011: op = alu_sltu;
            3'b100: op = alu_xor;
            3'b101: begin
                if (f7b5)   // srai shares the bit with sra
                    op = alu_sra;
                else
                    op = alu_srl;
            end
            3'b110: op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    always_comb begin
        alu_op   = alu_add;
        use_imm  = 1'b0;
        imm      = imm_i;
        kept     = 1'b0;
        rs1_used = 1'b0;
        rs2_used = 1'b0;
        case (opcode)
            op_reg: begin
                kept     = 1'b1;
                rs1_used = 1'b1;
                rs2_used = 1'b1;
                alu_op   = funct_op(funct3, alt, 1'b1);
            end
            op_imm: begin
                kept     = 1'b1;
                use_imm  = 1'b1;
                rs1_used = 1'b1;
                alu_op   = funct_op(funct3, alt, 1'b0);
            end
            op_lui: begin
                kept    = 1'b1;
                use_imm = 1'b1;
                imm     = imm_u;
                alu_op  = alu_pass_b;
            end
            default: ;  // No-op
        endcase
    end

    // Only place where x0 is protected
    assign writes_rd = kept && (rd != '0);

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::inst_t    inst,
    input  logic               we,
    input  core_pkg::reg_idx_t waddr,
    input  core_pkg::word_t    wdata,
    output core_pkg::word_t    rs1_data,
    output core_pkg::word_t    rs2_data
);
    import core_pkg::*;

    word_t    regs [reg_count];
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;

    assign rs1_idx = inst[19:15];
    assign rs2_idx = inst[24:20];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-through so a same-cycle write is visible
    function automatic word_t read_port(input reg_idx_t idx);
        word_t val;
        if (idx == '0)
            val = '0;
        else if (we && (waddr == idx))
            val = wdata;
        else
            val = regs[idx];
        return val;
    endfunction

    always_comb rs1_data = read_port(rs1_idx);
    always_comb rs2_data = read_port(rs2_idx);

endmodule

// File: hw/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               inst_valid,
    input  core_pkg::alu_op_e  alu_op,
    input  logic               use_imm,
    input  core_pkg::word_t    imm,
    input  core_pkg::reg_idx_t rd,
    input  logic               writes_rd,
    input  logic               rs1_used,
    input  logic               rs2_used,
    input  core_pkg::reg_idx_t rs1_idx,
    input  core_pkg::reg_idx_t rs2_idx,
    input  core_pkg::word_t    rs1_data,
    input  core_pkg::word_t    rs2_data,
    output logic               wb_valid,
    output core_pkg::reg_idx_t wb_rd,
    output core_pkg::word_t    wb_data
);
    import core_pkg::*;

    logic         de_valid;
    alu_op_e      de_alu_op;
    logic         de_use_imm;
    word_t        de_imm;
    reg_idx_t     de_rd;
    logic         de_rs1_used;
    logic         de_rs2_used;
    reg_idx_t     de_rs1_idx;
    reg_idx_t     de_rs2_idx;
    word_t        de_rs1_data;
    word_t        de_rs2_data;

    logic         fwd_a;
    logic         fwd_b;
    word_t        op_a;
    word_t        op_b;
    logic [shamt_w-1:0] shamt;
    word_t        alu_res;

    // Decode/execute register, only writing instructions become valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            de_valid <= 1'b0;
        else
            de_valid <= inst_valid && writes_rd;
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            de_alu_op   <= alu_op;
            de_use_imm  <= use_imm;
            de_imm      <= imm;
            de_rd       <= rd;
            de_rs1_used <= rs1_used;
            de_rs2_used <= rs2_used;
            de_rs1_idx  <= rs1_idx;
            de_rs2_idx  <= rs2_idx;
            de_rs1_data <= rs1_data;
            de_rs2_data <= rs2_data;
        end
    end

    // Previous instruction's result was not yet in the file at read time
    assign fwd_a = de_rs1_used && wb_valid && (wb_rd == de_rs1_idx);
    assign fwd_b = de_rs2_used && wb_valid && (wb_rd == de_rs2_idx);

    assign op_a  = fwd_a ? wb_data : de_rs1_data;
    assign op_b  = de_use_imm ? de_imm : (fwd_b ? wb_data : de_rs2_data);
    assign shamt = op_b[shamt_w-1:0];

    always_comb begin
        case (de_alu_op)
            alu_add:    alu_res = op_a + op_b;
            alu_sub:    alu_res = op_a - op_b;
            alu_and:    alu_res = op_a & op_b;
            alu_or:     alu_res = op_a | op_b;
            alu_xor:    alu_res = op_a ^ op_b;
            alu_sll:    alu_res = op_a << shamt;
            alu_srl:    alu_res = op_a >> shamt;
            alu_sra:    alu_res = $signed(op_a) >>> shamt;
            alu_slt:    alu_res = word_t'($signed(op_a) < $signed(op_b));
            alu_sltu:   alu_res = word_t'(op_a < op_b);
            alu_pass_b: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    // Write-back register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= de_valid;
    end

    always_ff @(posedge clk) begin
        if (de_valid) begin
            wb_rd   <= de_rd;
            wb_data <= alu_res;
        end
    end

endmodule

// File: hw/int_core.sv
`timescale 1ns/1ps

module int_core (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               inst_valid,
    input  core_pkg::inst_t    inst,
    output logic               wb_valid,
    output core_pkg::reg_idx_t wb_rd,
    output core_pkg::word_t    wb_data
);
    import core_pkg::*;

    alu_op_e  dec_alu_op;
    logic     dec_use_imm;
    word_t    dec_imm;
    reg_idx_t dec_rd;
    logic     dec_writes_rd;
    logic     dec_rs1_used;
    logic     dec_rs2_used;
    word_t    rf_rs1_data;
    word_t    rf_rs2_data;

    inst_decoder i_inst_decoder (
        .inst      (inst),
        .alu_op    (dec_alu_op),
        .use_imm   (dec_use_imm),
        .imm       (dec_imm),
        .rd        (dec_rd),
        .writes_rd (dec_writes_rd),
        .rs1_used  (dec_rs1_used),
        .rs2_used  (dec_rs2_used)
    );

    // Written from the write-back register two edges after issue
    reg_file i_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst     (inst),
        .we       (wb_valid),
        .waddr    (wb_rd),
        .wdata    (wb_data),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data)
    );

    exec_stage i_exec_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .alu_op     (dec_alu_op),
        .use_imm    (dec_use_imm),
        .imm        (dec_imm),
        .rd         (dec_rd),
        .writes_rd  (dec_writes_rd),
        .rs1_used   (dec_rs1_used),
        .rs2_used   (dec_rs2_used),
        .rs1_idx    (inst[19:15]),
        .rs2_idx    (inst[24:20]),
        .rs1_data   (rf_rs1_data),
        .rs2_data   (rf_rs2_data),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

// File: test/int_core_checker.sv
`timescale 1ns/1ps

module int_core_checker (
    input logic               clk,
    input logic               rst_n,
    input logic               inst_valid,
    input logic               writes_rd,
    input logic               wb_valid,
    input core_pkg::reg_idx_t wb_rd
);

    logic accept;
    int   fail_count = 0;   // Read by the testbench

    assign accept = inst_valid && writes_rd;   // Writing instruction taken this edge

    a_wb_follows: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> ##2 wb_valid)
        else begin
            $error("wb_valid missing two edges after an accepted write");
            fail_count++;
        end

    a_wb_caused: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> $past(accept, 2))
        else begin
            $error("wb_valid without a matching accepted write");
            fail_count++;
        end

    a_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb_rd != 5'd0)
        else begin
            $error("write-back targets x0");
            fail_count++;
        end

    // Pipeline comes out of reset empty
    a_reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !wb_valid)
        else begin
            $error("wb_valid high right after reset release");
            fail_count++;
        end

endmodule

bind int_core int_core_checker i_int_core_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .writes_rd  (dec_writes_rd),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd)
);

// File: test/tb_int_core.sv
`timescale 1ns/1ps

module tb_int_core;
    import core_pkg::*;

    localparam int          max_cycles = 3000;  // About 700 instructions plus gaps
    localparam logic [31:0] seed       = 32'h3c75;

    logic     clk;
    logic     rst_n;
    logic     inst_valid;
    inst_t    inst;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;

    word_t       ref_regs [reg_count];
    reg_idx_t    exp_rd [$];
    word_t       exp_data [$];
    int          head = 0;      // Index of the next expected write
    int          errors = 0;
    int          missing;
    int          mark;
    int          passed;
    int          failed;
    int          cycles = 0;
    logic [31:0] lcg_state;
    logic [6:0]  bad_ops [5] = '{7'b0000011, 7'b0100011, 7'b1100011, 7'b0010111, 7'b1101111};

    int_core i_int_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Compare every write pulse with the oldest pending expectation
    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            if (head >= exp_rd.size()) begin
                $display("Unexpected write to x%0d at %0t with nothing pending", wb_rd, $time);
                errors++;
            end else begin
                assert (wb_rd == exp_rd[head])
                else begin
                    $display("FAIL %0t: write to x%0d, expected x%0d", $time, wb_rd,
                             exp_rd[head]);
                    errors++;
                end
                assert (wb_data == exp_data[head])
                else begin
                    $display("FAIL %0t: x%0d = %h, expected %h", $time, wb_rd, wb_data,
                             exp_data[head]);
                    errors++;
                end
                head++;
            end
        end
    end

    // Monitor, end-of-test and bound assertion failures together
    function automatic int fault_count();
        return errors + missing + i_int_core.i_int_core_checker.fail_count;
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic inst_t enc_r(input logic [2:0] f3, input logic alt,
                                    input reg_idx_t rd, rs1, rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic inst_t enc_i(input logic [2:0] f3, input reg_idx_t rd, rs1,
                                    input logic [11:0] imm);
        return {imm, rs1, f3, rd, op_imm};
    endfunction

    function automatic inst_t enc_lui(input reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, op_lui};
    endfunction

    // Reference result of one instruction and whether it writes rd
    function automatic logic ref_exec(input inst_t in, output word_t val);
        logic [6:0] opc;
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        opc = in[6:0];
        f3  = in[14:12];
        a   = ref_regs[in[19:15]];
        b   = (opc == op_reg) ? ref_regs[in[24:20]] : {{52{in[31]}}, in[31:20]};
        val = '0;
        if (opc == op_lui) begin
            val = {{32{in[31]}}, in[31:12], 12'h000};
        end else if (opc == op_reg || opc == op_imm) begin
            case (f3)
                3'd0:    val = (opc == op_reg && in[30]) ? a - b : a + b;
                3'd1:    val = a << b[5:0];
                3'd2:    val = {63'd0, $signed(a) < $signed(b)};
                3'd3:    val = {63'd0, a < b};
                3'd4:    val = a ^ b;
                3'd5:    val = in[30] ? word_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
                3'd6:    val = a | b;
                default: val = a & b;
            endcase
        end else begin
            return 1'b0;    // Dropped opcode
        end
        return in[11:7] != 5'd0;
    endfunction

    function automatic reg_idx_t rand_reg();
        logic [31:0] r;
        r = lcg_next();
        return r[20:16];
    endfunction

    function automatic inst_t rand_r(input reg_idx_t rd, rs1, rs2);
        logic [31:0] r;
        r = lcg_next();
        return enc_r(r[18:16], (r[18:16] == 3'd0 || r[18:16] == 3'd5) && r[30], rd, rs1, rs2);
    endfunction

    function automatic inst_t rand_i(input reg_idx_t rd, rs1);
        logic [31:0] r;
        logic [11:0] imm;
        r   = lcg_next();
        imm = r[31:20];
        if (r[18:16] == 3'd1)
            imm = {6'h00, r[25:20]};
        else if (r[18:16] == 3'd5)
            imm = {1'b0, r[30], 4'h0, r[25:20]};    // srli or srai
        return enc_i(r[18:16], rd, rs1, imm);
    endfunction

    function automatic inst_t rand_any(input reg_idx_t rd, rs1, rs2);
        logic [31:0] r;
        r = lcg_next();
        if (r[23:22] == 2'd0)
            return enc_lui(rd, r[31:12]);
        else if (r[22])
            return rand_r(rd, rs1, rs2);
        return rand_i(rd, rs1);
    endfunction

    task automatic issue(input inst_t in);
        word_t val;
        if (ref_exec(in, val)) begin
            ref_regs[in[11:7]] = val;
            exp_rd.push_back(in[11:7]);
            exp_data.push_back(val);
        end
        inst_valid = 1'b1;
        inst       = in;
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic seed_regs();
        logic [31:0] r;
        for (int i = 1; i < reg_count; i++) begin
            r = lcg_next();
            issue(enc_lui(reg_idx_t'(i), r[31:12]));
            issue(enc_i(3'd0, reg_idx_t'(i), reg_idx_t'(i), r[11:0]));
        end
    endtask

    // Waits out the pipeline and reports the test
    task automatic end_test(input string name);
        int waited;
        waited = 0;
        while (head < exp_rd.size() && waited < 8) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (head < exp_rd.size()) begin
            $display("Test %s: %0d expected writes never appeared", name, exp_rd.size() - head);
            missing++;
        end
        if (fault_count() == mark) begin
            $display("Test %s: passed", name);
            passed++;
        end else begin
            $display("Test %s: failed", name);
            failed++;
        end
        mark = fault_count();
    endtask

    initial begin
        logic [31:0] r;
        reg_idx_t    d;
        reg_idx_t    p1;
        reg_idx_t    p2;
        clk        = 1'b0;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        lcg_state  = seed;
        missing    = 0;
        mark       = 0;
        passed     = 0;
        failed     = 0;
        foreach (ref_regs[i])
            ref_regs[i] = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        idle(5);
        issue(enc_i(3'd0, 5'd5, 5'd0, 12'h9a5));
        issue(enc_r(3'd0, 1'b0, 5'd6, 5'd7, 5'd8));   // Unwritten registers
        end_test("reset");

        seed_regs();
        repeat (150) issue(rand_r(rand_reg(), rand_reg(), rand_reg()));
        end_test("reg_reg");

        repeat (120) issue(rand_i(rand_reg(), rand_reg()));
        repeat (30) begin
            r = lcg_next();
            issue(enc_lui(rand_reg(), {r[15] | r[31], r[30:12]}));
        end
        end_test("imm_lui");

        seed_regs();
        p1 = 5'd1;
        p2 = 5'd2;
        repeat (100) begin   // Sources one or two instructions back
            d = rand_reg();
            if (d == 5'd0)
                d = 5'd3;
            r = lcg_next();
            if (r[18])
                issue(rand_r(d, r[16] ? p1 : p2, r[17] ? p1 : p2));
            else
                issue(rand_i(d, r[16] ? p1 : p2));
            p2 = p1;
            p1 = d;
        end
        end_test("forwarding");

        repeat (5) issue(rand_r(5'd0, rand_reg(), rand_reg()));
        repeat (5) issue(rand_i(5'd0, rand_reg()));
        for (int k = 0; k < 20; k++) begin
            r = lcg_next();
            issue({r[31:7], bad_ops[k % 5]});
        end
        issue(enc_r(3'd6, 1'b0, 5'd9, 5'd0, 5'd0));
        issue(enc_i(3'd0, 5'd10, 5'd0, 12'h000));
        end_test("x0_noop");

        repeat (150) begin
            issue(rand_any(rand_reg(), rand_reg(), rand_reg()));
            r = lcg_next();
            idle(int'(r[17:16]));
        end
        end_test("gaps");

        idle(3);
        $display("Tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0 && fault_count() == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: vlog.f
hw/core_pkg.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/exec_stage.sv
hw/int_core.sv
test/int_core_checker.sv
test/tb_int_core.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_int_core
FILELIST = vlog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
